// ==== logic/exec_pkg.sv ====
package exec_pkg;

    // datapath width
    localparam int XLEN = 32;

    // rob sizing, tag width follows from it
    localparam int ROB_ENTRIES = 8;
    localparam int TAG_W = $clog2(ROB_ENTRIES);

    // station sizes
    localparam int ALU_RS_SIZE = 4;
    localparam int MUL_RS_SIZE = 2;
    localparam int ALU_IDX_W = $clog2(ALU_RS_SIZE);
    localparam int MUL_IDX_W = $clog2(MUL_RS_SIZE);

    // bus clients: 0 is the alu station, 1 the mul station
    localparam int NUM_CDB_CLIENTS = 2;

    typedef logic [XLEN-1:0]      xlen_word_t;
    typedef logic [TAG_W-1:0]     rob_tag_t;
    typedef logic [ALU_IDX_W-1:0] alu_idx_t;
    typedef logic [MUL_IDX_W-1:0] mul_idx_t;

    // shifts use b[4:0]
    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu
    } alu_op_e;

    // low word, signed high word, unsigned high word
    typedef enum logic [1:0] {
        op_mul,
        op_mulh,
        op_mulhu
    } mul_op_e;

    typedef enum logic {
        unit_alu,
        unit_mul
    } unit_e;

    // value when ready, otherwise tag of the producer
    typedef struct packed {
        logic       ready;
        rob_tag_t   tag;
        xlen_word_t value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        unit_e    unit;
        alu_op_e  alu_op;
        mul_op_e  mul_op;
        rob_tag_t dest;
        operand_t src1;
        operand_t src2;
    } dispatch_t;

    typedef struct packed {
        logic       valid;
        rob_tag_t   tag;
        xlen_word_t value;
    } cdb_t;

    typedef struct packed {
        logic     in_use;
        logic     issued;
        logic     done;
        alu_op_e  op;
        rob_tag_t dest;
        operand_t src1;
        operand_t src2;
    } alu_entry_t;

    // operand after snooping the bus for its tag
    function automatic operand_t snoop_operand(operand_t opnd, cdb_t bus);
        operand_t res;
        res = opnd;
        if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

endpackage

// ==== logic/alu.sv ====
module alu import exec_pkg::*; (
    input  logic       clk,
    input  logic       load_i,
    input  alu_op_e    op_i,
    input  xlen_word_t a_i,
    input  xlen_word_t b_i,
    output xlen_word_t result_o,
    output logic       ready_o
);

    xlen_word_t f;
    logic [4:0] shamt;

    // rv32 shifts only look at the low five bits
    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            op_add:  f = a_i + b_i;
            op_sub:  f = a_i - b_i;
            op_and:  f = a_i & b_i;
            op_or:   f = a_i | b_i;
            op_xor:  f = a_i ^ b_i;
            op_sll:  f = a_i << shamt;
            op_srl:  f = a_i >> shamt;
            // arithmetic shift keeps the sign
            op_sra:  f = xlen_word_t'($signed(a_i) >>> shamt);
            op_slt:  f = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            op_sltu: f = {{(XLEN-1){1'b0}}, a_i < b_i};
            default: f = '0;
        endcase
    end

    // one result per load, ready the cycle after
    always_ff @(posedge clk) begin
        ready_o <= load_i;
        if (load_i) begin
            result_o <= f;
        end
    end

endmodule

// ==== logic/mul_unit.sv ====
module mul_unit import exec_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       flush_i,
    input  logic       start_i,
    input  mul_op_e    op_i,
    input  xlen_word_t a_i,
    input  xlen_word_t b_i,
    output xlen_word_t result_o,
    output logic       busy_o,
    output logic       done_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_finish
    } mul_state_e;

    mul_state_e          state_q;
    logic [4:0]          cnt_q;
    mul_op_e             op_q;
    logic                neg_q;
    xlen_word_t          mcand_q;
    logic [2*XLEN-1:0]   prod_q;
    logic [XLEN:0]       step_sum;
    logic [2*XLEN-1:0]   signed_prod;
    logic                signed_in;
    xlen_word_t          a_mag;
    xlen_word_t          b_mag;

    // only mulh treats its inputs as signed
    assign signed_in = (op_i == op_mulh);
    assign a_mag = (signed_in && a_i[XLEN-1]) ? -a_i : a_i;
    assign b_mag = (signed_in && b_i[XLEN-1]) ? -b_i : b_i;

    // add multiplicand into the upper half when the low bit is set
    assign step_sum = {1'b0, prod_q[2*XLEN-1:XLEN]} + (prod_q[0] ? {1'b0, mcand_q} : '0);
    assign signed_prod = neg_q ? -prod_q : prod_q;

    assign busy_o = (state_q != st_idle);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            state_q <= st_idle;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (start_i) begin
                        state_q <= st_run;
                    end
                end
                // 32 shift-add steps
                st_run: begin
                    if (cnt_q == 5'd31) begin
                        state_q <= st_finish;
                    end
                end
                st_finish: begin
                    state_q <= st_idle;
                    done_o  <= 1'b1;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state_q)
            st_idle: begin
                if (start_i) begin
                    op_q    <= op_i;
                    neg_q   <= signed_in && (a_i[XLEN-1] ^ b_i[XLEN-1]);
                    mcand_q <= a_mag;
                    prod_q  <= {{XLEN{1'b0}}, b_mag};
                    cnt_q   <= '0;
                end
            end
            st_run: begin
                prod_q <= {step_sum, prod_q[XLEN-1:1]};
                cnt_q  <= cnt_q + 5'd1;
            end
            st_finish: begin
                // low word for mul, high word otherwise
                result_o <= (op_q == op_mul) ? signed_prod[XLEN-1:0]
                                             : signed_prod[2*XLEN-1:XLEN];
            end
            default: cnt_q <= '0;
        endcase
    end

endmodule

// ==== logic/alu_rs.sv ====
module alu_rs import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  dispatch_t dispatch_i,
    input  logic      load_i,
    input  cdb_t      cdb_i,
    output logic      full_o,
    output logic      req_o,
    output cdb_t      req_data_o,
    input  logic      grant_i
);

    alu_entry_t             ent_q [ALU_RS_SIZE];
    xlen_word_t             res_q [ALU_RS_SIZE];
    xlen_word_t             alu_res [ALU_RS_SIZE];
    logic [ALU_RS_SIZE-1:0] alu_load;
    logic [ALU_RS_SIZE-1:0] alu_ready;
    logic [ALU_RS_SIZE-1:0] free_vec;
    logic [ALU_RS_SIZE-1:0] done_vec;
    alu_idx_t               free_idx;
    alu_idx_t               done_idx;
    alu_idx_t               sel_idx;
    alu_idx_t               sel_q;
    logic                   pend_q;

    always_comb begin
        free_idx = '0;
        done_idx = '0;
        for (int i = 0; i < ALU_RS_SIZE; i++) begin
            free_vec[i] = !ent_q[i].in_use;
            done_vec[i] = ent_q[i].in_use && ent_q[i].done;
            // issue once both operands are present
            alu_load[i] = ent_q[i].in_use && !ent_q[i].issued
                          && ent_q[i].src1.ready && ent_q[i].src2.ready;
        end
        // downward scan leaves the lowest index
        for (int i = ALU_RS_SIZE - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                free_idx = alu_idx_t'(i);
            end
            if (done_vec[i]) begin
                done_idx = alu_idx_t'(i);
            end
        end
    end

    assign full_o = !(|free_vec);
    assign req_o  = |done_vec;

    // lowest done entry, or the one still waiting for its grant
    assign sel_idx = pend_q ? sel_q : done_idx;

    assign req_data_o.valid = req_o;
    assign req_data_o.tag   = ent_q[sel_idx].dest;
    assign req_data_o.value = res_q[sel_idx];

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            for (int i = 0; i < ALU_RS_SIZE; i++) begin
                ent_q[i].in_use <= 1'b0;
                ent_q[i].issued <= 1'b0;
                ent_q[i].done   <= 1'b0;
            end
            pend_q <= 1'b0;
        end else begin
            for (int i = 0; i < ALU_RS_SIZE; i++) begin
                // wakeup from the bus
                ent_q[i].src1 <= snoop_operand(ent_q[i].src1, cdb_i);
                ent_q[i].src2 <= snoop_operand(ent_q[i].src2, cdb_i);
                if (alu_load[i]) begin
                    ent_q[i].issued <= 1'b1;
                end
                // ignore a stale ready from before a flush
                if (alu_ready[i] && ent_q[i].in_use && ent_q[i].issued) begin
                    ent_q[i].done <= 1'b1;
                end
            end

            // broadcast taken, free the entry
            if (req_o && grant_i) begin
                ent_q[sel_idx].in_use <= 1'b0;
                ent_q[sel_idx].issued <= 1'b0;
                ent_q[sel_idx].done   <= 1'b0;
            end

            // new instruction, same-cycle tag match captured here
            if (load_i && !full_o) begin
                ent_q[free_idx].in_use <= 1'b1;
                ent_q[free_idx].issued <= 1'b0;
                ent_q[free_idx].done   <= 1'b0;
                ent_q[free_idx].op     <= dispatch_i.alu_op;
                ent_q[free_idx].dest   <= dispatch_i.dest;
                ent_q[free_idx].src1   <= snoop_operand(dispatch_i.src1, cdb_i);
                ent_q[free_idx].src2   <= snoop_operand(dispatch_i.src2, cdb_i);
            end

            pend_q <= req_o && !grant_i;
        end
    end

    // results and offered index
    always_ff @(posedge clk) begin
        sel_q <= sel_idx;
        for (int i = 0; i < ALU_RS_SIZE; i++) begin
            if (alu_ready[i]) begin
                res_q[i] <= alu_res[i];
            end
        end
    end

    for (genvar g = 0; g < ALU_RS_SIZE; g++) begin : g_alu
        alu u_alu (
            .clk      (clk),
            .load_i   (alu_load[g]),
            .op_i     (ent_q[g].op),
            .a_i      (ent_q[g].src1.value),
            .b_i      (ent_q[g].src2.value),
            .result_o (alu_res[g]),
            .ready_o  (alu_ready[g])
        );
    end

endmodule

// ==== logic/mul_rs.sv ====
module mul_rs import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  dispatch_t dispatch_i,
    input  logic      load_i,
    input  cdb_t      cdb_i,
    output logic      full_o,
    output logic      req_o,
    output cdb_t      req_data_o,
    input  logic      grant_i
);

    typedef struct packed {
        logic     in_use;
        logic     issued;
        mul_op_e  op;
        rob_tag_t dest;
        operand_t src1;
        operand_t src2;
    } mul_entry_t;

    mul_entry_t             ent_q [MUL_RS_SIZE];
    logic [MUL_RS_SIZE-1:0] rdy_vec;
    mul_idx_t               older_q;
    mul_idx_t               free_idx;
    mul_idx_t               start_idx;
    mul_idx_t               run_q;
    logic                   start;
    logic                   hold_q;
    logic                   mul_busy;
    logic                   mul_done;
    xlen_word_t             mul_res;

    always_comb begin
        for (int i = 0; i < MUL_RS_SIZE; i++) begin
            rdy_vec[i] = ent_q[i].in_use && !ent_q[i].issued
                         && ent_q[i].src1.ready && ent_q[i].src2.ready;
        end
    end

    assign full_o   = ent_q[0].in_use && ent_q[1].in_use;
    assign free_idx = ent_q[0].in_use ? mul_idx_t'(1) : mul_idx_t'(0);

    // oldest ready entry first
    assign start_idx = rdy_vec[older_q] ? older_q : ~older_q;
    // multiplier free and no product waiting for the bus
    assign start = (|rdy_vec) && !mul_busy && !mul_done && !hold_q;

    assign req_o            = hold_q;
    assign req_data_o.valid = hold_q;
    assign req_data_o.tag   = ent_q[run_q].dest;
    assign req_data_o.value = mul_res;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            for (int i = 0; i < MUL_RS_SIZE; i++) begin
                ent_q[i].in_use <= 1'b0;
                ent_q[i].issued <= 1'b0;
            end
            hold_q  <= 1'b0;
            older_q <= '0;
        end else begin
            for (int i = 0; i < MUL_RS_SIZE; i++) begin
                ent_q[i].src1 <= snoop_operand(ent_q[i].src1, cdb_i);
                ent_q[i].src2 <= snoop_operand(ent_q[i].src2, cdb_i);
            end
            if (start) begin
                ent_q[start_idx].issued <= 1'b1;
                run_q <= start_idx;
            end
            if (mul_done) begin
                hold_q <= 1'b1;
            end
            // product broadcast, the other entry becomes oldest
            if (req_o && grant_i) begin
                hold_q               <= 1'b0;
                ent_q[run_q].in_use  <= 1'b0;
                ent_q[run_q].issued  <= 1'b0;
                older_q              <= ~run_q;
            end
            if (load_i && !full_o) begin
                ent_q[free_idx].in_use <= 1'b1;
                ent_q[free_idx].issued <= 1'b0;
                ent_q[free_idx].op     <= dispatch_i.mul_op;
                ent_q[free_idx].dest   <= dispatch_i.dest;
                ent_q[free_idx].src1   <= snoop_operand(dispatch_i.src1, cdb_i);
                ent_q[free_idx].src2   <= snoop_operand(dispatch_i.src2, cdb_i);
                // new entry is oldest only when it ends up alone
                if (!ent_q[~free_idx].in_use || (req_o && grant_i && run_q == ~free_idx)) begin
                    older_q <= free_idx;
                end else begin
                    older_q <= ~free_idx;
                end
            end
        end
    end

    mul_unit u_mul (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .start_i  (start),
        .op_i     (ent_q[start_idx].op),
        .a_i      (ent_q[start_idx].src1.value),
        .b_i      (ent_q[start_idx].src2.value),
        .result_o (mul_res),
        .busy_o   (mul_busy),
        .done_o   (mul_done)
    );

endmodule

// ==== logic/cdb_arbiter.sv ====
module cdb_arbiter import exec_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             flush_i,
    input  logic [NUM_CDB_CLIENTS-1:0]       req_i,
    input  cdb_t [NUM_CDB_CLIENTS-1:0]       data_i,
    output logic [NUM_CDB_CLIENTS-1:0]       grant_o,
    output cdb_t                             cdb_o
);

    // index of the last station that won the bus
    logic last_q;
    logic win;

    always_comb begin
        grant_o = req_i;
        // tie goes to whoever did not win last
        if (&req_i) begin
            grant_o = last_q ? 2'b01 : 2'b10;
        end
    end

    assign win = grant_o[1];

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            cdb_o.valid <= 1'b0;
            // alu station first after reset
            last_q <= 1'b1;
        end else begin
            cdb_o.valid <= |grant_o;
            if (|grant_o) begin
                // one-cycle broadcast of the winner's payload
                cdb_o.tag   <= data_i[win].tag;
                cdb_o.value <= data_i[win].value;
                last_q      <= win;
            end
        end
    end

endmodule

// ==== logic/exec_top.sv ====
module exec_top import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  dispatch_t dispatch_i,
    output logic      alu_full_o,
    output logic      mul_full_o,
    output cdb_t      cdb_o
);

    logic [NUM_CDB_CLIENTS-1:0] req;
    logic [NUM_CDB_CLIENTS-1:0] grant;
    cdb_t [NUM_CDB_CLIENTS-1:0] req_data;
    logic                       alu_load;
    logic                       mul_load;

    // steer by unit
    assign alu_load = dispatch_i.valid && (dispatch_i.unit == unit_alu);
    assign mul_load = dispatch_i.valid && (dispatch_i.unit == unit_mul);

    // client 0
    alu_rs u_alu_rs (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .dispatch_i (dispatch_i),
        .load_i     (alu_load),
        .cdb_i      (cdb_o),
        .full_o     (alu_full_o),
        .req_o      (req[0]),
        .req_data_o (req_data[0]),
        .grant_i    (grant[0])
    );

    // client 1
    mul_rs u_mul_rs (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .dispatch_i (dispatch_i),
        .load_i     (mul_load),
        .cdb_i      (cdb_o),
        .full_o     (mul_full_o),
        .req_o      (req[1]),
        .req_data_o (req_data[1]),
        .grant_i    (grant[1])
    );

    // registered bus fed back to both stations
    cdb_arbiter u_arb (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .req_i   (req),
        .data_i  (req_data),
        .grant_o (grant),
        .cdb_o   (cdb_o)
    );

endmodule

// ==== verif/exec_props.sv ====
module exec_props import exec_pkg::*; (
    input logic                       clk,
    input logic                       rst_n_i,
    input logic                       flush_i,
    input logic [NUM_CDB_CLIENTS-1:0] req_i,
    input cdb_t [NUM_CDB_CLIENTS-1:0] data_i,
    input logic [NUM_CDB_CLIENTS-1:0] grant_o
);

    // failed property count, read by the testbench
    int fail_count = 0;

    // at most one station owns the bus
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(grant_o))
        else begin
            $error("cdb grant is not one-hot or zero");
            fail_count++;
        end

    // grant only where a request is up
    a_grant_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        (grant_o & ~req_i) == '0)
        else begin
            $error("cdb grant given to a station without a request");
            fail_count++;
        end

    // a losing station keeps request and payload, a flush releases it
    for (genvar c = 0; c < NUM_CDB_CLIENTS; c++) begin : g_hold
        a_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
            req_i[c] && !grant_o[c] && !flush_i |=> req_i[c] && data_i[c] == $past(data_i[c]))
            else begin
                $error("station %0d dropped or changed its request before a grant", c);
                fail_count++;
            end
    end

endmodule

bind cdb_arbiter exec_props u_props (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .req_i   (req_i),
    .data_i  (data_i),
    .grant_o (grant_o)
);

// ==== verif/exec_tb.sv ====
module exec_tb import exec_pkg::*; ();

    // codes below zero pick a literal and the rest name an earlier row of the batch
    typedef enum int {
        src_rnd = -2,
        src_lit = -1
    } src_e;

    typedef enum logic [1:0] {
        k_plain,
        k_sync,
        k_full,
        k_flush
    } row_kind_e;

    typedef struct packed {
        unit_e      unit;
        alu_op_e    aop;
        mul_op_e    mop;
        row_kind_e  kind;
        logic       last;
        int         k1;
        xlen_word_t v1;
        int         k2;
        xlen_word_t v2;
    } row_t;

    logic       clk;
    logic       rst_n_i;
    logic       flush_i;
    dispatch_t  dispatch_i;
    logic       alu_full_o;
    logic       mul_full_o;
    cdb_t       cdb_o;

    row_t       rows [$];
    string      names [$];
    xlen_word_t expected [ROB_ENTRIES];
    logic       inflight [ROB_ENTRIES];
    logic       seen [ROB_ENTRIES];
    int         cur_base;
    int         cycles;
    int         cycle_limit;
    logic [63:0] lcg_state;

    exec_top dut (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .dispatch_i (dispatch_i),
        .alu_full_o (alu_full_o),
        .mul_full_o (mul_full_o),
        .cdb_o      (cdb_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // 64-bit lcg that returns its upper half
    function automatic xlen_word_t lcg_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[63:32];
    endfunction

    // reference alu with rv32 semantics
    function automatic xlen_word_t alu_expect(alu_op_e op, xlen_word_t a, xlen_word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            op_add:  return a + b;
            op_sub:  return a + ~b + 32'd1;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << sh;
            op_srl:  return a >> sh;
            // fill vacated bits with the sign
            op_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            // flipping the sign bit turns signed order into unsigned order
            op_slt:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            op_sltu: return (a < b) ? 32'd1 : 32'd0;
            default: return 32'h0;
        endcase
    endfunction

    // reference multiply on full 64-bit products
    function automatic xlen_word_t mul_expect(mul_op_e op, xlen_word_t a, xlen_word_t b);
        logic signed [63:0] sp;
        logic [63:0]        up;
        sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up = {32'h0, a} * {32'h0, b};
        case (op)
            op_mulh:  return sp[63:32];
            op_mulhu: return up[63:32];
            default:  return up[31:0];
        endcase
    endfunction

    task automatic add_row(input string name, input unit_e u, input alu_op_e aop,
                           input mul_op_e mop, input int k1, input xlen_word_t v1,
                           input int k2, input xlen_word_t v2, input row_kind_e kind);
        row_t r;
        r.unit = u;
        r.aop  = aop;
        r.mop  = mop;
        r.kind = kind;
        r.last = 1'b0;
        r.k1   = k1;
        r.v1   = (k1 == src_rnd) ? lcg_next() : v1;
        r.k2   = k2;
        r.v2   = (k2 == src_rnd) ? lcg_next() : v2;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic alu_row(input string name, input alu_op_e op, input int k1,
                           input xlen_word_t v1, input int k2, input xlen_word_t v2,
                           input row_kind_e kind = k_plain);
        add_row(name, unit_alu, op, op_mul, k1, v1, k2, v2, kind);
    endtask

    task automatic mul_row(input string name, input mul_op_e op, input int k1,
                           input xlen_word_t v1, input int k2, input xlen_word_t v2,
                           input row_kind_e kind = k_plain);
        add_row(name, unit_mul, op_add, op, k1, v1, k2, v2, kind);
    endtask

    task automatic end_batch();
        row_t r;
        r = rows[rows.size() - 1];
        r.last = 1'b1;
        rows[rows.size() - 1] = r;
    endtask

    task automatic build_table();
        // every alu op on random operands
        alu_row("add_rnd", op_add, src_rnd, 0, src_rnd, 0);
        alu_row("sub_rnd", op_sub, src_rnd, 0, src_rnd, 0);
        alu_row("and_rnd", op_and, src_rnd, 0, src_rnd, 0);
        alu_row("or_rnd", op_or, src_rnd, 0, src_rnd, 0);
        alu_row("xor_rnd", op_xor, src_rnd, 0, src_rnd, 0);
        alu_row("sll_rnd", op_sll, src_rnd, 0, src_rnd, 0);
        alu_row("srl_rnd", op_srl, src_rnd, 0, src_rnd, 0);
        alu_row("sra_rnd", op_sra, src_rnd, 0, src_rnd, 0);
        end_batch();
        // edge values
        alu_row("slt_rnd", op_slt, src_rnd, 0, src_rnd, 0);
        alu_row("sltu_rnd", op_sltu, src_rnd, 0, src_rnd, 0);
        alu_row("add_ones", op_add, src_lit, 32'hffff_ffff, src_lit, 32'd1);
        alu_row("sub_min", op_sub, src_lit, 32'h8000_0000, src_lit, 32'd1);
        alu_row("sra_min_31", op_sra, src_lit, 32'h8000_0000, src_lit, 32'd31);
        alu_row("sll_sh0", op_sll, src_rnd, 0, src_lit, 32'd0);
        alu_row("srl_ones_31", op_srl, src_lit, 32'hffff_ffff, src_lit, 32'd31);
        alu_row("slt_min", op_slt, src_lit, 32'h8000_0000, src_lit, 32'd0);
        end_batch();
        alu_row("sltu_min", op_sltu, src_lit, 32'h8000_0000, src_lit, 32'd0);
        alu_row("slt_ones", op_slt, src_lit, 32'hffff_ffff, src_lit, 32'd0);
        alu_row("xor_ones", op_xor, src_rnd, 0, src_lit, 32'hffff_ffff);
        alu_row("and_zero", op_and, src_rnd, 0, src_lit, 32'd0);
        alu_row("sra_shamt_mask", op_sra, src_rnd, 0, src_lit, 32'h0000_003f);
        end_batch();
        // multiplies
        mul_row("mul_rnd", op_mul, src_rnd, 0, src_rnd, 0);
        mul_row("mulh_rnd", op_mulh, src_rnd, 0, src_rnd, 0);
        mul_row("mulhu_rnd", op_mulhu, src_rnd, 0, src_rnd, 0);
        mul_row("mulh_neg_neg", op_mulh, src_lit, 32'hffff_fff9, src_lit, 32'h8000_0000);
        mul_row("mulh_neg_pos", op_mulh, src_lit, 32'h8000_0000, src_lit, 32'h7fff_ffff);
        mul_row("mul_neg_neg", op_mul, src_lit, 32'hffff_ffff, src_lit, 32'hffff_ffff);
        mul_row("mulhu_ones", op_mulhu, src_lit, 32'hffff_ffff, src_lit, 32'hffff_ffff);
        end_batch();
        // dependency chains where the last two go out while the producer is on the bus
        alu_row("chain_add", op_add, src_rnd, 0, src_rnd, 0);
        alu_row("chain_alu_alu", op_sub, 0, 0, src_rnd, 0);
        mul_row("chain_alu_mul", op_mul, 1, 0, src_rnd, 0);
        alu_row("chain_mul_alu", op_xor, 2, 0, 0, 0);
        mul_row("chain_mulhu", op_mulhu, 3, 0, 2, 0);
        alu_row("chain_sync_mul", op_add, 4, 0, src_rnd, 0, k_sync);
        alu_row("chain_sync_alu", op_sll, 5, 0, src_rnd, 0, k_sync);
        end_batch();
        // four alu rows stuck behind one multiply
        mul_row("bp_mul", op_mul, src_rnd, 0, src_rnd, 0);
        alu_row("bp_add", op_add, 0, 0, src_rnd, 0);
        alu_row("bp_sub", op_sub, 0, 0, src_rnd, 0);
        alu_row("bp_and", op_and, 0, 0, src_rnd, 0);
        alu_row("bp_or", op_or, 0, 0, src_rnd, 0, k_full);
        end_batch();
        // flushed while everything waits
        mul_row("fl_mulh", op_mulh, src_rnd, 0, src_rnd, 0);
        alu_row("fl_add", op_add, 0, 0, src_rnd, 0);
        alu_row("fl_sub", op_sub, 1, 0, src_rnd, 0);
        alu_row("fl_xor", op_xor, 0, 0, src_rnd, 0);
        alu_row("fl_and", op_and, 0, 0, src_rnd, 0, k_flush);
        end_batch();
        alu_row("post_add", op_add, src_rnd, 0, src_rnd, 0);
        mul_row("post_mul", op_mul, 0, 0, src_rnd, 0);
        alu_row("post_sltu", op_sltu, 1, 0, 0, 0);
        end_batch();
    endtask

    // value when already broadcast and the producer tag otherwise
    task automatic make_operand(input int k, input xlen_word_t lit,
                                output operand_t opnd, output xlen_word_t val);
        opnd = '0;
        if (k >= 0) begin
            val        = expected[k];
            opnd.tag   = rob_tag_t'(k);
            opnd.ready = seen[k];
            opnd.value = seen[k] ? expected[k] : '0;
        end else begin
            val        = lit;
            opnd.ready = 1'b1;
            opnd.value = lit;
        end
    endtask

    task automatic do_flush();
        flush_i = 1'b1;
        @(posedge clk);
        #2;
        flush_i = 1'b0;
        for (int i = 0; i < ROB_ENTRIES; i++) begin
            inflight[i] = 1'b0;
        end
        // nothing may come out for longer than a whole multiply
        repeat (45) begin
            assert (cdb_o.valid === 1'b0)
                else abort_run("cdb_o valid after flush with no new dispatch");
            assert (alu_full_o === 1'b0 && mul_full_o === 1'b0)
                else abort_run("full flag high after flush with no new dispatch");
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_row(input int p, input row_t r);
        operand_t   o1;
        operand_t   o2;
        xlen_word_t a;
        xlen_word_t b;
        while ((r.unit == unit_alu) ? alu_full_o : mul_full_o) begin
            @(posedge clk);
            #2;
        end
        // hold back until the producer tag sits on the bus
        if (r.kind == k_sync) begin
            while (!(cdb_o.valid === 1'b1 && cdb_o.tag == rob_tag_t'(r.k1))) begin
                @(posedge clk);
                #2;
            end
        end
        make_operand(r.k1, r.v1, o1, a);
        make_operand(r.k2, r.v2, o2, b);
        expected[p] = (r.unit == unit_alu) ? alu_expect(r.aop, a, b) : mul_expect(r.mop, a, b);
        inflight[p] = 1'b1;
        dispatch_i.valid  = 1'b1;
        dispatch_i.unit   = r.unit;
        dispatch_i.alu_op = r.aop;
        dispatch_i.mul_op = r.mop;
        dispatch_i.dest   = rob_tag_t'(p);
        dispatch_i.src1   = o1;
        dispatch_i.src2   = o2;
        @(posedge clk);
        #2;
        dispatch_i.valid = 1'b0;
        if (r.kind == k_full) begin
            assert (alu_full_o === 1'b1)
                else abort_run($sformatf("MISMATCH %s expected %0d actual %0d",
                               names[cur_base + p], 1, alu_full_o));
        end
        if (r.kind == k_flush) begin
            do_flush();
        end
    endtask

    function automatic logic any_inflight();
        for (int i = 0; i < ROB_ENTRIES; i++) begin
            if (inflight[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // scoreboard on the registered bus
    always @(posedge clk) begin
        rob_tag_t t;
        row_t     r;
        if (rst_n_i && cdb_o.valid === 1'b1) begin
            t = cdb_o.tag;
            assert (inflight[t])
                else abort_run($sformatf("broadcast for tag %0d that is not in flight", t));
            r = rows[cur_base + t];
            assert (cdb_o.value === expected[t])
                else abort_run($sformatf("MISMATCH %s expected %08h actual %08h",
                               names[cur_base + t], expected[t], cdb_o.value));
            // a consumer never finishes before its producer
            if (r.k1 >= 0) begin
                assert (seen[r.k1])
                    else abort_run($sformatf("tag %0d broadcast before its producer", t));
            end
            if (r.k2 >= 0) begin
                assert (seen[r.k2])
                    else abort_run($sformatf("tag %0d broadcast before its producer", t));
            end
            inflight[t] = 1'b0;
            seen[t]     = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        assert (cycles < cycle_limit)
            else abort_run("timeout, the run did not finish within the cycle limit");
        assert (dut.u_arb.u_props.fail_count == 0)
            else abort_run("a bus arbiter property failed");
    end

    initial begin
        rst_n_i    = 1'b0;
        flush_i    = 1'b0;
        dispatch_i = '0;
        cycles     = 0;
        cur_base   = 0;
        lcg_state  = 64'd59;
        for (int i = 0; i < ROB_ENTRIES; i++) begin
            inflight[i] = 1'b0;
            seen[i]     = 1'b0;
            expected[i] = '0;
        end
        build_table();
        cycle_limit = rows.size() * 60 + 200;

        repeat (10) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        assert (cdb_o.valid === 1'b0 && alu_full_o === 1'b0 && mul_full_o === 1'b0)
            else abort_run("bus valid or full flag not low after reset");

        for (int i = 0; i < rows.size(); i++) begin
            // tags restart at zero for a new batch
            if (i == 0 || rows[i - 1].last) begin
                cur_base = i;
                for (int j = 0; j < ROB_ENTRIES; j++) begin
                    seen[j] = 1'b0;
                end
            end
            run_row(i - cur_base, rows[i]);
            if (rows[i].last) begin
                while (any_inflight()) begin
                    @(posedge clk);
                    #2;
                end
            end
        end

        // quiet tail catches stray broadcasts
        repeat (10) @(posedge clk);
        if (dut.u_arb.u_props.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run("a bus arbiter property failed");
        end
    end

endmodule

// ==== files.f ====
logic/exec_pkg.sv
logic/alu.sv
logic/mul_unit.sv
logic/alu_rs.sv
logic/mul_rs.sv
logic/cdb_arbiter.sv
logic/exec_top.sv
verif/exec_props.sv
verif/exec_tb.sv
